// ==== dv/core_trace.hex ====
// columns: inst, branch_valid, branch_taken, branch_target, wb_valid, wb_addr, wb_data
// pc of line k is 4*k
3C011234 0 0 00000000 1 01 12340000 // lui r1
34215678 0 0 00000000 1 01 12345678 // ori r1, alu forward
2402FFFB 0 0 00000000 1 02 FFFFFFFB // addiu r2, -5
340300F0 0 0 00000000 1 03 000000F0
00232024 0 0 00000000 1 04 00000070 // and
00432825 0 0 00000000 1 05 FFFFFFFB // or, r3 from ex register
00223026 0 0 00000000 1 06 EDCBA983 // xor
00603827 0 0 00000000 1 07 FFFFFF0F // nor
00224021 0 0 00000000 1 08 12345673 // addu
00614823 0 0 00000000 1 09 EDCBAA78 // subu
0043502A 0 0 00000000 1 0A 00000001 // slt
0043582B 0 0 00000000 1 0B 00000000 // sltu
286CFFFF 0 0 00000000 1 0C 00000000 // slti -1
2C6DFFFF 0 0 00000000 1 0D 00000001 // sltiu -1
00027100 0 0 00000000 1 0E FFFFFFB0 // sll 4
00027902 0 0 00000000 1 0F 0FFFFFFF // srl 4
00028103 0 0 00000000 1 10 FFFFFFFF // sra 4
24110007 0 0 00000000 1 11 00000007
02319021 0 0 00000000 1 12 0000000E // distance 1
02329821 0 0 00000000 1 13 00000015 // distance 2 and 1
24000055 0 0 00000000 0 00 00000000 // write to r0
0013A021 0 0 00000000 1 14 00000015 // reads r0
08000040 1 1 00000100 0 00 00000000 // j
2415000E 0 0 00000000 1 15 0000000E
12B20004 1 1 00000070 0 00 00000000 // beq equal
16B2FFF8 1 0 00000044 0 00 00000000 // bne equal
24160003 0 0 00000000 1 16 00000003
12D50002 1 0 00000074 0 00 00000000 // beq unequal
16D5FFFF 1 1 0000006C 0 00 00000000 // bne unequal

// ==== dv/tb_mips_core_slice.sv ====
`default_nettype none
`timescale 1ns/1ps

module tb_mips_core_slice;

	localparam int NUM_TESTS    = 29;
	localparam int TRACE_COLS   = 7;
	localparam int RESET_CYCLES = 5;
	localparam int CLK_PERIOD   = 100;

	// trace columns
	localparam int COL_INST   = 0;
	localparam int COL_BV     = 1;
	localparam int COL_BT     = 2;
	localparam int COL_TARGET = 3;
	localparam int COL_WV     = 4;
	localparam int COL_WA     = 5;
	localparam int COL_WD     = 6;

	logic        clk;
	logic        reset_i;
	logic        inst_valid_i;
	logic [31:0] inst_i;
	logic [31:0] pc_i;
	logic        branch_valid_o;
	logic        branch_taken_o;
	logic [31:0] branch_target_o;
	logic        wb_valid_o;
	logic [4:0]  wb_addr_o;
	logic [31:0] wb_data_o;

	logic [31:0] trace [NUM_TESTS*TRACE_COLS];
	logic        test_bad [NUM_TESTS];
	logic        reset_bad;
	int          error_count;
	int          pass_count;
	int          fail_count;

	mips_core_slice mips_core_slice_inst (
		.clk             (clk),
		.reset_i         (reset_i),
		.inst_valid_i    (inst_valid_i),
		.inst_i          (inst_i),
		.pc_i            (pc_i),
		.branch_valid_o  (branch_valid_o),
		.branch_taken_o  (branch_taken_o),
		.branch_target_o (branch_target_o),
		.wb_valid_o      (wb_valid_o),
		.wb_addr_o       (wb_addr_o),
		.wb_data_o       (wb_data_o)
	);

	always #(CLK_PERIOD/2) clk = ~clk;

	function automatic logic [31:0] expected(input int k, input int col);
		return trace[k*TRACE_COLS + col];
	endfunction

	task automatic check_value(input string name, input string what,
			input logic [31:0] exp_val, input logic [31:0] act_val, inout logic bad);
		assert (act_val === exp_val) else begin
			$display("ERROR %s %s expected 0x%08h actual 0x%08h", name, what, exp_val, act_val);
			error_count++;
			bad = 1'b1;
		end
	endtask

	// branch report is visible one cycle after the instruction was sampled
	task automatic check_branch(input int k);
		string name;
		name = $sformatf("t%02d", k);
		check_value(name, "branch_valid", expected(k, COL_BV), {31'b0, branch_valid_o},
			test_bad[k]);
		check_value(name, "branch_taken", expected(k, COL_BT), {31'b0, branch_taken_o},
			test_bad[k]);
		if (expected(k, COL_BV) != 0)
			check_value(name, "branch_target", expected(k, COL_TARGET), branch_target_o,
				test_bad[k]);
	endtask

	// writeback lands two cycles after the branch report, then the test is done
	task automatic check_writeback(input int k);
		string name;
		name = $sformatf("t%02d", k);
		check_value(name, "wb_valid", expected(k, COL_WV), {31'b0, wb_valid_o}, test_bad[k]);
		if (expected(k, COL_WV) != 0) begin
			check_value(name, "wb_addr", expected(k, COL_WA), {27'b0, wb_addr_o}, test_bad[k]);
			check_value(name, "wb_data", expected(k, COL_WD), wb_data_o, test_bad[k]);
		end
		if (test_bad[k]) begin
			fail_count++;
			$display("%s inst %08h: failed", name, expected(k, COL_INST));
		end else begin
			pass_count++;
			$display("%s inst %08h: ok", name, expected(k, COL_INST));
		end
	endtask

	initial begin
		clk = 1'b0;
		reset_i = 1'b1;
		inst_valid_i = 1'b0;
		inst_i = '0;
		pc_i = '0;
		reset_bad = 1'b0;
		error_count = 0;
		pass_count = 0;
		fail_count = 0;
		for (int k = 0; k < NUM_TESTS; k++)
			test_bad[k] = 1'b0;
		$readmemh("dv/core_trace.hex", trace);

		repeat (RESET_CYCLES) @(negedge clk);
		check_value("reset", "branch_valid", 32'h0, {31'b0, branch_valid_o}, reset_bad);
		check_value("reset", "branch_target", 32'h0, branch_target_o, reset_bad);
		check_value("reset", "wb_valid", 32'h0, {31'b0, wb_valid_o}, reset_bad);
		if (reset_bad) begin
			fail_count++;
			$display("reset: failed");
		end else begin
			pass_count++;
			$display("reset: ok");
		end
		reset_i = 1'b0;

		// one instruction per cycle with the checks trailing behind
		for (int cyc = 0; cyc < NUM_TESTS + 3; cyc++) begin
			if (cyc >= 1 && cyc <= NUM_TESTS)
				check_branch(cyc - 1);
			if (cyc >= 3)
				check_writeback(cyc - 3);
			if (cyc < NUM_TESTS) begin
				inst_valid_i = 1'b1;
				inst_i = expected(cyc, COL_INST);
				pc_i = cyc * 4;
			end else begin
				inst_valid_i = 1'b0;
				inst_i = '0;
			end
			@(negedge clk);
		end

		$display("tests passed %0d, failed %0d, check errors %0d",
			pass_count, fail_count, error_count);
		if (error_count == 0 && fail_count == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

	// watchdog
	initial begin
		#((RESET_CYCLES + NUM_TESTS + 10) * CLK_PERIOD);
		$display("timeout: the run did not reach the end of the trace in time");
		$display("TEST FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== logic/core_ifs.sv ====
`default_nettype none
`timescale 1ns/1ps

// decoded instruction handed from decode to execute
interface issue_if import core_pkg::*; ();

	logic      valid;
	alu_op_e   alu_op;
	word_t     operand_a;
	word_t     operand_b;
	reg_addr_t dest;
	logic      write_en;

	modport decode_mp (
		output valid, alu_op, operand_a, operand_b, dest, write_en
	);

	modport execute_mp (
		input valid, alu_op, operand_a, operand_b, dest, write_en
	);

endinterface

// two asynchronous register file read ports
interface reg_read_if import core_pkg::*; ();

	reg_addr_t rs_addr;
	reg_addr_t rt_addr;
	word_t     rs_data;
	word_t     rt_data;

	modport decode_mp (
		output rs_addr, rt_addr,
		input  rs_data, rt_data
	);

	modport result_mp (
		input  rs_addr, rt_addr,
		output rs_data, rt_data
	);

endinterface

`default_nettype wire

// ==== logic/core_pkg.sv ====
`default_nettype none

package core_pkg;

	localparam int XLEN       = 32;
	localparam int REG_ADDR_W = 5;
	localparam int NUM_REGS   = 32;

	typedef logic [XLEN-1:0] word_t;
	typedef logic [REG_ADDR_W-1:0] reg_addr_t;

	// r0 is hardwired to zero
	localparam reg_addr_t LINK_REG_ZERO = '0;
	localparam word_t RESET_PC = '0;

	// internal ALU micro-ops
	typedef enum logic [3:0] {
		ALU_NOP,
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_NOR,
		ALU_SLT,
		ALU_SLTU,
		ALU_SLL,
		ALU_SRL,
		ALU_SRA,
		ALU_LUI
	} alu_op_e;

endpackage

`default_nettype wire

// ==== logic/decode_stage.sv ====
`default_nettype none
`timescale 1ns/1ps

module decode_stage
	import mips_isa_pkg::*;
	import core_pkg::*;
(
	input  wire             clk,
	input  wire             reset_i,
	input  wire             inst_valid_i,
	input  word_t           inst_i,
	input  word_t           pc_i,
	reg_read_if.decode_mp   rf,
	input  wire             alu_fwd_valid_i,
	input  wire             alu_fwd_write_en_i,
	input  reg_addr_t       alu_fwd_dest_i,
	input  word_t           alu_fwd_data_i,
	input  wire             ex_valid_i,
	input  wire             ex_write_en_i,
	input  reg_addr_t       ex_dest_i,
	input  word_t           ex_data_i,
	issue_if.decode_mp      issue,
	output logic            branch_valid_o,
	output logic            branch_taken_o,
	output word_t           branch_target_o
);

	opcode_e                opcode;
	funct_e                 funct;
	reg_addr_t              rs;
	reg_addr_t              rt;
	reg_addr_t              rd;
	logic [SHAMT_W-1:0]     shamt;
	logic [IMM16_W-1:0]     imm16;
	logic [IMM26_W-1:0]     imm26;
	word_t                  imm_sext;
	word_t                  imm_zext;
	word_t                  rs_val;
	word_t                  rt_val;

	alu_op_e                alu_op_d;
	word_t                  opa_d;
	word_t                  opb_d;
	reg_addr_t              dest_d;
	logic                   wr_d;
	logic                   br_d;
	logic                   br_taken_d;
	word_t                  br_target_d;

	// ALU output first, then the execute register, then the file
	function automatic word_t fwd_operand(input reg_addr_t addr, input word_t rf_val);
		if (addr == LINK_REG_ZERO)
			return rf_val;
		if (alu_fwd_valid_i && alu_fwd_write_en_i && alu_fwd_dest_i == addr)
			return alu_fwd_data_i;
		if (ex_valid_i && ex_write_en_i && ex_dest_i == addr)
			return ex_data_i;
		return rf_val;
	endfunction

	assign opcode   = opcode_e'(inst_i[RS_LSB+REG_FIELD_W +: OPCODE_W]);
	assign funct    = funct_e'(inst_i[0 +: FUNCT_W]);
	assign rs       = inst_i[RS_LSB +: REG_FIELD_W];
	assign rt       = inst_i[RT_LSB +: REG_FIELD_W];
	assign rd       = inst_i[RD_LSB +: REG_FIELD_W];
	assign shamt    = inst_i[SHAMT_LSB +: SHAMT_W];
	assign imm16    = inst_i[0 +: IMM16_W];
	assign imm26    = inst_i[0 +: IMM26_W];
	assign imm_sext = {{(XLEN-IMM16_W){imm16[IMM16_W-1]}}, imm16};
	assign imm_zext = {{(XLEN-IMM16_W){1'b0}}, imm16};

	assign rf.rs_addr = rs;
	assign rf.rt_addr = rt;

	always_comb begin
		rs_val = fwd_operand(rs, rf.rs_data);
		rt_val = fwd_operand(rt, rf.rt_data);
	end

	// opcode and funct to micro-op, operands and destination
	always_comb begin
		alu_op_d = ALU_NOP;
		opa_d = rs_val;
		opb_d = rt_val;
		dest_d = rt;
		wr_d = 1'b1;
		case (opcode)
			OP_ADDIU: alu_op_d = ALU_ADD;
			OP_SLTI:  alu_op_d = ALU_SLT;
			OP_SLTIU: alu_op_d = ALU_SLTU;
			OP_ANDI:  alu_op_d = ALU_AND;
			OP_ORI:   alu_op_d = ALU_OR;
			OP_XORI:  alu_op_d = ALU_XOR;
			OP_LUI:   alu_op_d = ALU_LUI;
			OP_SPECIAL: begin
				dest_d = rd;
				case (funct)
					F_SLL:  alu_op_d = ALU_SLL;
					F_SRL:  alu_op_d = ALU_SRL;
					F_SRA:  alu_op_d = ALU_SRA;
					F_ADDU: alu_op_d = ALU_ADD;
					F_SUBU: alu_op_d = ALU_SUB;
					F_AND:  alu_op_d = ALU_AND;
					F_OR:   alu_op_d = ALU_OR;
					F_XOR:  alu_op_d = ALU_XOR;
					F_NOR:  alu_op_d = ALU_NOR;
					F_SLT:  alu_op_d = ALU_SLT;
					F_SLTU: alu_op_d = ALU_SLTU;
					default: wr_d = 1'b0;
				endcase
			end
			default: wr_d = 1'b0;
		endcase

		// immediate forms take the imm as operand b
		if (opcode inside {OP_ADDIU, OP_SLTI, OP_SLTIU})
			opb_d = imm_sext;
		else if (opcode inside {OP_ANDI, OP_ORI, OP_XORI, OP_LUI})
			opb_d = imm_zext;

		// shifts move rt by shamt
		if (opcode == OP_SPECIAL && alu_op_d inside {ALU_SLL, ALU_SRL, ALU_SRA}) begin
			opa_d = rt_val;
			opb_d = {{(XLEN-SHAMT_W){1'b0}}, shamt};
		end

		if (dest_d == LINK_REG_ZERO)
			wr_d = 1'b0;
	end

	// branch resolution on forwarded operands
	always_comb begin
		br_d = opcode inside {OP_J, OP_BEQ, OP_BNE};
		br_taken_d = 1'b0;
		br_target_d = pc_i + {imm_sext[XLEN-3:0], 2'b00};
		case (opcode)
			OP_J: begin
				br_taken_d = 1'b1;
				br_target_d = {pc_i[XLEN-1 -: XLEN-IMM26_W-2], imm26, 2'b00};
			end
			OP_BEQ: br_taken_d = (rs_val == rt_val);
			OP_BNE: br_taken_d = (rs_val != rt_val);
			default: br_taken_d = 1'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset_i) begin
			issue.valid <= 1'b0;
			issue.write_en <= 1'b0;
			issue.alu_op <= ALU_NOP;
			branch_valid_o <= 1'b0;
			branch_taken_o <= 1'b0;
			branch_target_o <= RESET_PC;
		end else begin
			issue.valid <= inst_valid_i;
			issue.write_en <= inst_valid_i & wr_d;
			issue.alu_op <= alu_op_d;
			branch_valid_o <= inst_valid_i & br_d;
			branch_taken_o <= inst_valid_i & br_taken_d;
			if (inst_valid_i && br_d)
				branch_target_o <= br_target_d;
		end
	end

	// operand payload
	always_ff @(posedge clk) begin
		issue.operand_a <= opa_d;
		issue.operand_b <= opb_d;
		issue.dest <= dest_d;
	end

	a_taken_is_branch: assert property (@(posedge clk) disable iff (reset_i)
		branch_taken_o |-> branch_valid_o);

endmodule

`default_nettype wire

// ==== logic/execute_stage.sv ====
`default_nettype none
`timescale 1ns/1ps

module execute_stage
	import mips_isa_pkg::*;
	import core_pkg::*;
(
	input  wire             clk,
	input  wire             reset_i,
	issue_if.execute_mp     issue,
	output logic            alu_fwd_valid_o,
	output logic            alu_fwd_write_en_o,
	output reg_addr_t       alu_fwd_dest_o,
	output word_t           alu_fwd_data_o,
	output logic            ex_valid_o,
	output logic            ex_write_en_o,
	output reg_addr_t       ex_dest_o,
	output word_t           ex_data_o
);

	word_t              alu_res;
	logic [SHAMT_W-1:0] sh;

	assign sh = issue.operand_b[SHAMT_W-1:0];

	always_comb begin
		case (issue.alu_op)
			ALU_ADD:  alu_res = issue.operand_a + issue.operand_b;
			ALU_SUB:  alu_res = issue.operand_a - issue.operand_b;
			ALU_AND:  alu_res = issue.operand_a & issue.operand_b;
			ALU_OR:   alu_res = issue.operand_a | issue.operand_b;
			ALU_XOR:  alu_res = issue.operand_a ^ issue.operand_b;
			ALU_NOR:  alu_res = ~(issue.operand_a | issue.operand_b);
			ALU_SLT:  alu_res = word_t'($signed(issue.operand_a) < $signed(issue.operand_b));
			ALU_SLTU: alu_res = word_t'(issue.operand_a < issue.operand_b);
			ALU_SLL:  alu_res = issue.operand_a << sh;
			ALU_SRL:  alu_res = issue.operand_a >> sh;
			// arithmetic shift keeps the sign bit
			ALU_SRA:  alu_res = word_t'($signed(issue.operand_a) >>> sh);
			ALU_LUI:  alu_res = {issue.operand_b[IMM16_W-1:0], {(XLEN-IMM16_W){1'b0}}};
			default:  alu_res = '0;
		endcase
	end

	// ex-stage forwarding source
	assign alu_fwd_valid_o = issue.valid;
	assign alu_fwd_write_en_o = issue.write_en;
	assign alu_fwd_dest_o = issue.dest;
	assign alu_fwd_data_o = alu_res;

	always_ff @(posedge clk) begin
		if (reset_i) begin
			ex_valid_o <= 1'b0;
			ex_write_en_o <= 1'b0;
		end else begin
			ex_valid_o <= issue.valid;
			ex_write_en_o <= issue.write_en;
		end
	end

	always_ff @(posedge clk) begin
		ex_dest_o <= issue.dest;
		ex_data_o <= alu_res;
	end

	a_no_write_when_idle: assert property (@(posedge clk) disable iff (reset_i)
		!issue.valid |-> !issue.write_en);

endmodule

`default_nettype wire

// ==== logic/mips_core_slice.sv ====
`default_nettype none
`timescale 1ns/1ps

module mips_core_slice
	import core_pkg::*;
(
	input  wire             clk,
	input  wire             reset_i,
	input  wire             inst_valid_i,
	input  word_t           inst_i,
	input  word_t           pc_i,
	output logic            branch_valid_o,
	output logic            branch_taken_o,
	output word_t           branch_target_o,
	output logic            wb_valid_o,
	output reg_addr_t       wb_addr_o,
	output word_t           wb_data_o
);

	// combinational ALU result
	logic      alu_fwd_valid;
	logic      alu_fwd_write_en;
	reg_addr_t alu_fwd_dest;
	word_t     alu_fwd_data;

	// execute register
	logic      ex_valid;
	logic      ex_write_en;
	reg_addr_t ex_dest;
	word_t     ex_data;

	issue_if    issue_bus ();
	reg_read_if rf_bus ();

	decode_stage decode_stage_inst (
		.clk                (clk),
		.reset_i            (reset_i),
		.inst_valid_i       (inst_valid_i),
		.inst_i             (inst_i),
		.pc_i               (pc_i),
		.rf                 (rf_bus.decode_mp),
		.alu_fwd_valid_i    (alu_fwd_valid),
		.alu_fwd_write_en_i (alu_fwd_write_en),
		.alu_fwd_dest_i     (alu_fwd_dest),
		.alu_fwd_data_i     (alu_fwd_data),
		.ex_valid_i         (ex_valid),
		.ex_write_en_i      (ex_write_en),
		.ex_dest_i          (ex_dest),
		.ex_data_i          (ex_data),
		.issue              (issue_bus.decode_mp),
		.branch_valid_o     (branch_valid_o),
		.branch_taken_o     (branch_taken_o),
		.branch_target_o    (branch_target_o)
	);

	execute_stage execute_stage_inst (
		.clk                (clk),
		.reset_i            (reset_i),
		.issue              (issue_bus.execute_mp),
		.alu_fwd_valid_o    (alu_fwd_valid),
		.alu_fwd_write_en_o (alu_fwd_write_en),
		.alu_fwd_dest_o     (alu_fwd_dest),
		.alu_fwd_data_o     (alu_fwd_data),
		.ex_valid_o         (ex_valid),
		.ex_write_en_o      (ex_write_en),
		.ex_dest_o          (ex_dest),
		.ex_data_o          (ex_data)
	);

	result_stage result_stage_inst (
		.clk           (clk),
		.reset_i       (reset_i),
		.ex_valid_i    (ex_valid),
		.ex_write_en_i (ex_write_en),
		.ex_dest_i     (ex_dest),
		.ex_data_i     (ex_data),
		.rf            (rf_bus.result_mp),
		.wb_valid_o    (wb_valid_o),
		.wb_addr_o     (wb_addr_o),
		.wb_data_o     (wb_data_o)
	);

endmodule

`default_nettype wire

// ==== logic/mips_isa_pkg.sv ====
`default_nettype none

package mips_isa_pkg;

	// instruction field widths
	localparam int OPCODE_W    = 6;
	localparam int REG_FIELD_W = 5;
	localparam int SHAMT_W     = 5;
	localparam int FUNCT_W     = 6;
	localparam int IMM16_W     = 16;
	localparam int IMM26_W     = 26;

	// lsb position of each field
	localparam int RS_LSB    = 21;
	localparam int RT_LSB    = 16;
	localparam int RD_LSB    = 11;
	localparam int SHAMT_LSB = 6;

	// primary opcodes of the supported subset
	typedef enum logic [OPCODE_W-1:0] {
		OP_SPECIAL = 6'h00,
		OP_J       = 6'h02,
		OP_BEQ     = 6'h04,
		OP_BNE     = 6'h05,
		OP_ADDIU   = 6'h09,
		OP_SLTI    = 6'h0a,
		OP_SLTIU   = 6'h0b,
		OP_ANDI    = 6'h0c,
		OP_ORI     = 6'h0d,
		OP_XORI    = 6'h0e,
		OP_LUI     = 6'h0f
	} opcode_e;

	// function codes under SPECIAL
	typedef enum logic [FUNCT_W-1:0] {
		F_SLL  = 6'h00,
		F_SRL  = 6'h02,
		F_SRA  = 6'h03,
		F_ADDU = 6'h21,
		F_SUBU = 6'h23,
		F_AND  = 6'h24,
		F_OR   = 6'h25,
		F_XOR  = 6'h26,
		F_NOR  = 6'h27,
		F_SLT  = 6'h2a,
		F_SLTU = 6'h2b
	} funct_e;

endpackage

`default_nettype wire

// ==== logic/result_stage.sv ====
`default_nettype none
`timescale 1ns/1ps

module result_stage
	import core_pkg::*;
(
	input  wire             clk,
	input  wire             reset_i,
	input  wire             ex_valid_i,
	input  wire             ex_write_en_i,
	input  reg_addr_t       ex_dest_i,
	input  word_t           ex_data_i,
	reg_read_if.result_mp   rf,
	output logic            wb_valid_o,
	output reg_addr_t       wb_addr_o,
	output word_t           wb_data_o
);

	word_t regs [NUM_REGS];
	logic  wr_en;

	assign wr_en = ex_valid_i & ex_write_en_i;

	always_ff @(posedge clk) begin
		if (reset_i) begin
			for (int i = 0; i < NUM_REGS; i++)
				regs[i] <= '0;
		end else if (wr_en) begin
			regs[ex_dest_i] <= ex_data_i;
		end
	end

	// read ports give zero for r0
	assign rf.rs_data = (rf.rs_addr == LINK_REG_ZERO) ? '0 : regs[rf.rs_addr];
	assign rf.rt_data = (rf.rt_addr == LINK_REG_ZERO) ? '0 : regs[rf.rt_addr];

	// writeback report
	always_ff @(posedge clk) begin
		if (reset_i)
			wb_valid_o <= 1'b0;
		else
			wb_valid_o <= wr_en;
	end

	always_ff @(posedge clk) begin
		wb_addr_o <= ex_dest_i;
		wb_data_o <= ex_data_i;
	end

	// decode must have dropped any write aimed at r0
	a_no_r0_write: assert property (@(posedge clk) disable iff (reset_i)
		wr_en |-> (ex_dest_i != LINK_REG_ZERO));

endmodule

`default_nettype wire

// ==== project.f ====
logic/mips_isa_pkg.sv
logic/core_pkg.sv
logic/core_ifs.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/result_stage.sv
logic/mips_core_slice.sv
dv/tb_mips_core_slice.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the testbench, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f project.f \
	--top-module tb_mips_core_slice -o sim_tb > build.log 2>&1 \
	|| { cat build.log; echo "build failed"; exit 1; }
./obj_dir/sim_tb > sim.log 2>&1 ; cat sim.log
grep -qx "TEST PASS" sim.log && exit 0 || exit 1
